// ==== design/sa_dims_pkg.sv ====
`default_nettype none

package sa_dims_pkg;

    // Square matrix side and element count
    localparam int DIM   = 8;
    localparam int ELEMS = DIM * DIM;

    // Raw input and weight element
    typedef logic signed [7:0] data_t;

    // Q, K and V element, 8 products of 16 bits
    typedef logic signed [19:0] proj_t;

    // Score element before and after ReLU
    typedef logic signed [40:0] score_t;

    // Weighted-sum result
    typedef logic signed [63:0] out_t;

    // Flat row-major index
    typedef logic [5:0] idx_t;

    typedef logic [3:0] len_t;

endpackage

`default_nettype wire

// ==== design/sa_ctrl_pkg.sv ====
`default_nettype none

package sa_ctrl_pkg;

    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_LOAD_Q = 3'd1,
        PH_LOAD_K = 3'd2,
        PH_LOAD_V = 3'd3,
        PH_SCORE  = 3'd4,
        PH_OUTPUT = 3'd5
    } phase_t;

    // Cycles per phase
    localparam int LOAD_LEN  = 64;
    localparam int SCORE_LEN = 64;

    // Legal sequence lengths
    localparam int T_SHORT = 1;
    localparam int T_MID   = 4;
    localparam int T_FULL  = 8;

endpackage

`default_nettype wire

// ==== design/sa_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_ctrl (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    input  wire sa_dims_pkg::len_t t_len,
    output sa_ctrl_pkg::phase_t    phase,
    output sa_dims_pkg::idx_t      cnt,
    output sa_dims_pkg::len_t      seq_len
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    logic [6:0] out_len;
    idx_t       out_last;

    // Output phase runs T rows of DIM results
    assign out_len  = {seq_len, 3'b000};
    assign out_last = idx_t'(out_len - 7'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_IDLE;
            cnt     <= '0;
            seq_len <= len_t'(T_SHORT);
        end else begin
            case (phase)
                PH_IDLE: begin
                    cnt <= '0;
                    if (in_valid) begin
                        phase   <= PH_LOAD_Q;
                        seq_len <= t_len;
                    end
                end
                PH_LOAD_Q: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == idx_t'(LOAD_LEN - 1)) begin
                        phase <= PH_LOAD_K;
                    end
                end
                PH_LOAD_K: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == idx_t'(LOAD_LEN - 1)) begin
                        phase <= PH_LOAD_V;
                    end
                end
                PH_LOAD_V: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == idx_t'(LOAD_LEN - 1)) begin
                        phase <= PH_SCORE;
                    end
                end
                PH_SCORE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == idx_t'(SCORE_LEN - 1)) begin
                        phase <= PH_OUTPUT;
                    end
                end
                PH_OUTPUT: begin
                    if (cnt == out_last) begin
                        phase <= PH_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    a_t_len_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == PH_IDLE && in_valid) |-> (t_len inside {T_SHORT, T_MID, T_FULL}));

    // Load beats are registered, so each load cycle follows a valid beat
    a_load_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (phase inside {PH_LOAD_Q, PH_LOAD_K, PH_LOAD_V}) |-> $past(in_valid));

endmodule

`default_nettype wire

// ==== design/sa_input_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_input_buf (
    input  wire logic                clk,
    input  wire sa_ctrl_pkg::phase_t phase,
    input  wire sa_dims_pkg::idx_t   cnt,
    input  wire sa_dims_pkg::data_t  in_data,
    input  wire sa_dims_pkg::data_t  w_q,
    input  wire sa_dims_pkg::len_t   seq_len,
    output sa_dims_pkg::data_t       x_col [sa_dims_pkg::DIM],
    output sa_dims_pkg::data_t       wq_elem
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    data_t      in_data_q;
    data_t      w_q_q;
    data_t      x_mem  [ELEMS];
    data_t      wq_mem [ELEMS];
    logic [6:0] x_limit;

    // Beat n lands here while cnt is n
    always_ff @(posedge clk) begin
        in_data_q <= in_data;
        w_q_q     <= w_q;
    end

    assign x_limit = {seq_len, 3'b000};

    // Rows of X past T are stored as zero
    always_ff @(posedge clk) begin
        if (phase == PH_LOAD_Q) begin
            x_mem[cnt]  <= ({1'b0, cnt} < x_limit) ? in_data_q : data_t'(0);
            wq_mem[cnt] <= w_q_q;
        end
    end

    // Column k of X for weight row k
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            x_col[i] = x_mem[{3'(i), cnt[5:3]}];
        end
    end

    assign wq_elem = wq_mem[cnt];

endmodule

`default_nettype wire

// ==== design/sa_proj.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_proj (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sa_ctrl_pkg::phase_t phase,
    input  wire sa_dims_pkg::idx_t   cnt,
    input  wire sa_dims_pkg::data_t  x_col [sa_dims_pkg::DIM],
    input  wire sa_dims_pkg::data_t  wq_elem,
    input  wire sa_dims_pkg::data_t  w_k,
    input  wire sa_dims_pkg::data_t  w_v,
    output sa_dims_pkg::proj_t       q_row [sa_dims_pkg::DIM],
    output sa_dims_pkg::proj_t       k_row [sa_dims_pkg::DIM],
    output sa_dims_pkg::proj_t       v_col [sa_dims_pkg::DIM]
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    data_t w_k_q;
    data_t w_v_q;
    data_t kv_w;
    proj_t q_acc   [ELEMS];
    proj_t k_acc   [ELEMS];
    proj_t v_acc   [ELEMS];
    proj_t q_prod  [DIM];
    proj_t kv_prod [DIM];

    always_ff @(posedge clk) begin
        w_k_q <= w_k;
        w_v_q <= w_v;
    end

    // K and V share one multiplier per lane
    assign kv_w = (phase == PH_LOAD_V) ? w_v_q : w_k_q;

    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            q_prod[i]  = proj_t'(x_col[i]) * proj_t'(wq_elem);
            kv_prod[i] = proj_t'(x_col[i]) * proj_t'(kv_w);
        end
    end

    // Lane i owns row i; weight element k,j feeds column j
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < ELEMS; e++) begin
                q_acc[e] <= '0;
                k_acc[e] <= '0;
                v_acc[e] <= '0;
            end
        end else begin
            case (phase)
                PH_LOAD_Q: begin
                    for (int e = 0; e < ELEMS; e++) begin
                        q_acc[e] <= '0;
                        k_acc[e] <= '0;
                        v_acc[e] <= '0;
                    end
                end
                PH_LOAD_K: begin
                    for (int i = 0; i < DIM; i++) begin
                        q_acc[{3'(i), cnt[2:0]}] <= q_acc[{3'(i), cnt[2:0]}] + q_prod[i];
                        k_acc[{3'(i), cnt[2:0]}] <= k_acc[{3'(i), cnt[2:0]}] + kv_prod[i];
                    end
                end
                PH_LOAD_V: begin
                    for (int i = 0; i < DIM; i++) begin
                        v_acc[{3'(i), cnt[2:0]}] <= v_acc[{3'(i), cnt[2:0]}] + kv_prod[i];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Q row i and K row j for score i,j; V column j for output i,j
    always_comb begin
        for (int j = 0; j < DIM; j++) begin
            q_row[j] = q_acc[{cnt[5:3], 3'(j)}];
            k_row[j] = k_acc[{cnt[2:0], 3'(j)}];
            v_col[j] = v_acc[{3'(j), cnt[2:0]}];
        end
    end

endmodule

`default_nettype wire

// ==== design/sa_score.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_score (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sa_ctrl_pkg::phase_t phase,
    input  wire sa_dims_pkg::idx_t   cnt,
    input  wire sa_dims_pkg::proj_t  q_row [sa_dims_pkg::DIM],
    input  wire sa_dims_pkg::proj_t  k_row [sa_dims_pkg::DIM],
    output sa_dims_pkg::score_t      s_row [sa_dims_pkg::DIM]
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    score_t s_mem [ELEMS];
    score_t dot;
    score_t relu_div;

    always_comb begin
        dot = '0;
        for (int j = 0; j < DIM; j++) begin
            dot = dot + score_t'(q_row[j]) * score_t'(k_row[j]);
        end
    end

    // ReLU, then truncating divide by 3
    assign relu_div = dot[$bits(score_t)-1] ? score_t'(0) : dot / score_t'(3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < ELEMS; e++) begin
                s_mem[e] <= '0;
            end
        end else if (phase == PH_SCORE) begin
            s_mem[cnt] <= relu_div;
        end
    end

    // Row i of S for output row i
    always_comb begin
        for (int j = 0; j < DIM; j++) begin
            s_row[j] = s_mem[{cnt[5:3], 3'(j)}];
        end
    end

    a_score_nonneg: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == PH_SCORE) |=> (s_mem[$past(cnt)] >= 0));

endmodule

`default_nettype wire

// ==== design/sa_attn_out.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_attn_out (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire sa_ctrl_pkg::phase_t phase,
    input  wire sa_dims_pkg::score_t s_row [sa_dims_pkg::DIM],
    input  wire sa_dims_pkg::proj_t  v_col [sa_dims_pkg::DIM],
    output logic                     out_valid,
    output sa_dims_pkg::out_t        out_data
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    out_t dot;

    // Row of S against column of V
    always_comb begin
        dot = '0;
        for (int j = 0; j < DIM; j++) begin
            dot = dot + out_t'(s_row[j]) * out_t'(v_col[j]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (phase == PH_OUTPUT) begin
            out_valid <= 1'b1;
            out_data  <= dot;
        end else begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end
    end

    a_out_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0));

endmodule

`default_nettype wire

// ==== design/sa_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    input  wire sa_dims_pkg::len_t  t_len,
    input  wire sa_dims_pkg::data_t in_data,
    input  wire sa_dims_pkg::data_t w_q,
    input  wire sa_dims_pkg::data_t w_k,
    input  wire sa_dims_pkg::data_t w_v,
    output logic                    out_valid,
    output sa_dims_pkg::out_t       out_data
);
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    phase_t phase;
    idx_t   cnt;
    len_t   seq_len;
    data_t  x_col [DIM];
    data_t  wq_elem;
    proj_t  q_row [DIM];
    proj_t  k_row [DIM];
    proj_t  v_col [DIM];
    score_t s_row [DIM];

    sa_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .t_len    (t_len),
        .phase    (phase),
        .cnt      (cnt),
        .seq_len  (seq_len)
    );

    sa_input_buf u_input_buf (
        .clk     (clk),
        .phase   (phase),
        .cnt     (cnt),
        .in_data (in_data),
        .w_q     (w_q),
        .seq_len (seq_len),
        .x_col   (x_col),
        .wq_elem (wq_elem)
    );

    sa_proj u_proj (
        .clk     (clk),
        .rst_n   (rst_n),
        .phase   (phase),
        .cnt     (cnt),
        .x_col   (x_col),
        .wq_elem (wq_elem),
        .w_k     (w_k),
        .w_v     (w_v),
        .q_row   (q_row),
        .k_row   (k_row),
        .v_col   (v_col)
    );

    sa_score u_score (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .cnt   (cnt),
        .q_row (q_row),
        .k_row (k_row),
        .s_row (s_row)
    );

    sa_attn_out u_attn_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .s_row     (s_row),
        .v_col     (v_col),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_sa.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sa;
    import sa_dims_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int BEATS           = 3 * LOAD_LEN;
    localparam int CYCLES_PER_TEST = BEATS + SCORE_LEN + 64 + 20;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    len_t  t_len;
    data_t in_data;
    data_t w_q;
    data_t w_k;
    data_t w_v;
    logic  out_valid;
    out_t  out_data;

    int     seed = 32'hdbca_5394;
    int     num_tests;
    int     data_errs;
    int     window_errs;
    int     other_errs;
    data_t  x_m  [DIM][DIM];
    data_t  wq_m [DIM][DIM];
    data_t  wk_m [DIM][DIM];
    data_t  wv_m [DIM][DIM];
    out_t   exp_out [ELEMS];
    byte    kind_q [$];
    int     t_q [$];
    int     x_q [$];
    int     wq_q [$];
    int     wk_q [$];
    int     wv_q [$];
    longint exp_q [$];

    sa_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_len     (t_len),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_out(input out_t got, input out_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: out_data%s got %0d, expected %0d", $time, what, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_valid_count(input idx_t got_last, input idx_t exp_last);
        if (got_last !== exp_last) begin
            $display("Mismatch at %0t: out_valid last index got %0d, expected %0d",
                     $time, got_last, exp_last);
            window_errs++;
        end
    endtask

    task automatic check_valid_level(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: out_valid got %b, expected %b", $time, got, exp);
            window_errs++;
        end
    endtask

    task automatic read_tests();
        int     fd;
        int     n;
        int     t;
        int     x;
        int     wq;
        int     wk;
        int     wv;
        longint expv;
        string  line;
        fd = $fopen("test/sa_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/sa_stim.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d",
                        t, x, wq, wk, wv, expv);
            if (n != 6 || !(line.getc(0) inside {"c", "r"})) begin
                $display("Malformed test line: %s", line);
                other_errs++;
                continue;
            end
            kind_q.push_back(line.getc(0));
            t_q.push_back(t);
            x_q.push_back(x);
            wq_q.push_back(wq);
            wk_q.push_back(wk);
            wv_q.push_back(wv);
            exp_q.push_back(expv);
        end
        $fclose(fd);
        num_tests = kind_q.size();
    endtask

    // Plain matrix math, rows of X at T and above are zero
    function automatic void build_reference(input int t);
        longint q [DIM][DIM];
        longint k [DIM][DIM];
        longint v [DIM][DIM];
        longint s [DIM][DIM];
        longint acc;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                q[i][j] = 0;
                k[i][j] = 0;
                v[i][j] = 0;
                for (int n = 0; n < DIM; n++) begin
                    if (i < t) begin
                        q[i][j] += longint'(x_m[i][n]) * longint'(wq_m[n][j]);
                        k[i][j] += longint'(x_m[i][n]) * longint'(wk_m[n][j]);
                        v[i][j] += longint'(x_m[i][n]) * longint'(wv_m[n][j]);
                    end
                end
            end
        end
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                acc = 0;
                for (int n = 0; n < DIM; n++) acc += q[i][n] * k[j][n];
                s[i][j] = (acc > 0) ? acc / 3 : 0;
            end
        end
        for (int i = 0; i < DIM; i++) begin
            for (int c = 0; c < DIM; c++) begin
                acc = 0;
                for (int j = 0; j < DIM; j++) acc += s[i][j] * v[j][c];
                exp_out[i * DIM + c] = (i < t) ? acc : 0;
            end
        end
    endfunction

    task automatic load_matrices(input int n);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                if (kind_q[n] == "c") begin
                    x_m[i][j]  = data_t'(x_q[n]);
                    wq_m[i][j] = data_t'(wq_q[n]);
                    wk_m[i][j] = data_t'(wk_q[n]);
                    wv_m[i][j] = data_t'(wv_q[n]);
                    exp_out[i * DIM + j] = (i < t_q[n]) ? exp_q[n] : 0;
                end else begin
                    x_m[i][j]  = data_t'($random(seed));
                    wq_m[i][j] = data_t'($random(seed));
                    wk_m[i][j] = data_t'($random(seed));
                    wv_m[i][j] = data_t'($random(seed));
                end
            end
        end
        if (kind_q[n] == "r") build_reference(t_q[n]);
    endtask

    // Starts and ends on a falling edge
    task automatic run_job(input int t);
        int r;
        int c;
        int count;
        int waited;
        bit seen;
        bit done;
        for (int b = 0; b < BEATS; b++) begin
            r        = (b % LOAD_LEN) / DIM;
            c        = b % DIM;
            in_valid = 1'b1;
            t_len    = len_t'(t);
            in_data  = (b < LOAD_LEN) ? x_m[r][c] : data_t'(0);
            w_q      = (b < LOAD_LEN) ? wq_m[r][c] : data_t'(0);
            w_k      = (b / LOAD_LEN == 1) ? wk_m[r][c] : data_t'(0);
            w_v      = (b / LOAD_LEN == 2) ? wv_m[r][c] : data_t'(0);
            @(negedge clk);
            // Output stays quiet while the matrices load
            check_valid_level(out_valid, 1'b0);
            check_out(out_data, '0, " (load)");
        end
        in_valid = 1'b0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        count    = 0;
        waited   = 0;
        seen     = 1'b0;
        done     = 1'b0;
        while (!done) begin
            if (out_valid) begin
                if (count < t * DIM) begin
                    check_out(out_data, exp_out[count], $sformatf("[%0d]", count));
                end
                count++;
                seen = 1'b1;
            end else begin
                check_out(out_data, '0, " (idle)");
                done = seen;
            end
            waited++;
            if (!done && waited > SCORE_LEN + t * DIM + 8) begin
                $display("Output window for T=%0d did not end in time", t);
                other_errs++;
                done = 1'b1;
            end
            if (!done) @(negedge clk);
        end
        if (count == 0) begin
            $display("No out_valid window seen for T=%0d", t);
            window_errs++;
        end else if (count > ELEMS) begin
            $display("out_valid stayed high for %0d cycles for T=%0d", count, t);
            window_errs++;
        end else begin
            check_valid_count(idx_t'(count - 1), idx_t'(t * DIM - 1));
        end
    endtask

    initial begin
        wait (num_tests > 0);
        #(num_tests * CYCLES_PER_TEST * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Watchdog expired before %0d tests finished", num_tests);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        t_len       = len_t'(T_SHORT);
        in_data     = '0;
        w_q         = '0;
        w_k         = '0;
        w_v         = '0;
        data_errs   = 0;
        window_errs = 0;
        other_errs  = 0;
        num_tests   = 0;
        read_tests();
        if (num_tests == 0 && other_errs == 0) begin
            $display("No tests found in test/sa_stim.txt");
            other_errs++;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_valid_level(out_valid, 1'b0);
        check_out(out_data, '0, " (reset)");
        // Each job starts as soon as the previous output window closes
        for (int n = 0; n < num_tests; n++) begin
            load_matrices(n);
            run_job(t_q[n]);
        end
        $display("Error counts: data %0d, window %0d, other %0d",
                 data_errs, window_errs, other_errs);
        if (data_errs + window_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/sa_stim.txt ====
# kind T x wq wk wv expected
# kind c is constant matrices, kind r is random matrices checked by the model (x..expected unused)
c 1 1 1 1 1 1360
c 4 2 3 1 2 262144
c 8 -3 2 5 -4 11796480
c 8 -128 -128 -128 127 -47663096055644160
c 4 3 2 -1 5 0
c 8 -7 -4 9 3 0
r 1 0 0 0 0 0
r 4 0 0 0 0 0
r 8 0 0 0 0 0
r 8 0 0 0 0 0
c 1 1 1 1 1 1360

// ==== src.f ====
design/sa_dims_pkg.sv
design/sa_ctrl_pkg.sv
design/sa_ctrl.sv
design/sa_input_buf.sv
design/sa_proj.sv
design/sa_score.sv
design/sa_attn_out.sv
design/sa_top.sv
test/tb_sa.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_sa \
    --Mdir obj_dir -o tb_sa_sim

status=0
./obj_dir/tb_sa_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
